//--- verilog/tilemap_consts.svh
// line buffer, tile row, start position and rom word constants for the tilemap renderer
`ifndef TILEMAP_CONSTS_SVH
`define TILEMAP_CONSTS_SVH

// line buffer geometry
`define TM_BUF_DEPTH 512
`define TM_BUF_LAST 9'd447 // last visible buffer address, ends the line

// first tile ram address of the row, per tile size
`define TM_TILE_START_8  8'd0
`define TM_TILE_START_16 8'd128
`define TM_TILE_START_32 8'd224

// buffer start position per tile size
// drawing begins inside the blanking area so the visible part is complete
`define TM_BUF0_8  9'h038
`define TM_BUF0_16 9'h030
`define TM_BUF0_32 9'h020

// planar graphics rom word, 8 pixels of 4 bits
`define TM_ROM_DW 32

`endif

//--- verilog/tilemap_pkg.sv
// pixel, tile attribute, bank selection and scroll configuration types
package tilemap_pkg;

    // one line buffer entry
    typedef struct packed {
        logic [1:0] group;  // priority group
        logic [4:0] pal;
        logic [3:0] colour;
    } pixel_t;

    // attribute word, the odd tile ram entry
    typedef struct packed {
        logic [6:0] unused;
        logic [1:0] group;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } tile_attr_t;

    // mapper result for one tile code
    typedef struct packed {
        logic [3:0] offset;   // rom address bits 19..16
        logic [3:0] mask;
        logic       unmapped; // tile drawn as colour 15
    } bank_sel_t;

    // layer configuration
    typedef struct packed {
        logic [15:0] hpos;
        logic [15:0] vpos;
        logic [2:0]  size;    // one-hot: bit 0 8x8, bit 1 16x16, bit 2 32x32
        logic        flip;    // screen flip
    } scroll_cfg_t;

endpackage

//--- verilog/gfx_mapper.sv
// gfx_mapper: registered tile code to graphics rom bank translation
`timescale 1ns/1ns

module gfx_mapper (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             layer,       // 1..3, zero when no size is selected
    input  logic [9:0]             cin,         // tile code bits 15..6
    input  logic [15:0]            bank_offset, // one nibble per bank
    input  logic [15:0]            bank_mask,
    output tilemap_pkg::bank_sel_t sel
);

    logic [1:0] bank;
    logic [3:0] offset_nib;
    logic [3:0] mask_nib;

    // bank index sits in the top two code bits
    assign bank = cin[9:8];

    always_comb begin
        offset_nib = bank_offset[{bank, 2'b00} +: 4];
        mask_nib   = bank_mask[{bank, 2'b00} +: 4];
    end

    // all layers share one table here
    // a game table would branch on layer and the lower code bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else begin
            sel.offset   <= offset_nib;
            sel.mask     <= mask_nib;
            sel.unmapped <= (mask_nib == 4'h0) || (layer == 2'd0); // empty bank or no layer
        end
    end

endmodule

//--- verilog/tile_line_render.sv
// tile_line_render: tile row walker, rom word fetch and planar pixel serializer
`timescale 1ns/1ns
`include "tilemap_consts.svh"

module tile_line_render (
    input  logic                     clk,
    input  logic                     rst,
    input  tilemap_pkg::scroll_cfg_t cfg,
    input  logic [8:0]               vrender,   // line being prepared
    input  logic                     start,
    input  logic                     stop,
    output logic                     done,
    output logic [7:0]               tile_addr,
    input  logic [15:0]              tile_data,
    output logic [9:0]               map_code,
    output logic [1:0]               map_layer,
    input  tilemap_pkg::bank_sel_t   sel,
    output logic [19:0]              rom_addr,
    output logic                     rom_half,
    input  logic [`TM_ROM_DW-1:0]    rom_data,
    input  logic                     rom_ok,
    output logic                     rom_cs,
    output logic [8:0]               buf_addr,
    output tilemap_pkg::pixel_t      buf_data,
    output logic                     buf_wr
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,   // code address at the ram
        S_CODE,   // code word returns
        S_ATTR,   // attribute word returns
        S_MAP,    // mapper result valid
        S_ISSUE,
        S_WAIT,   // wait for rom_ok
        S_DRAW
    } state_t;

    state_t                  state;
    logic [4:0]              vn;          // only the row bits are needed
    logic [15:0]             code;
    tilemap_pkg::tile_attr_t attr;
    tilemap_pkg::bank_sel_t  bank;
    logic [`TM_ROM_DW-1:0]   pxl;
    logic [2:0]              pix_cnt;
    logic [1:0]              word_idx;
    logic [1:0]              last_word;
    logic [8:0]              vr_eff;
    logic [8:0]              buf0;
    logic [8:0]              fine;
    logic [7:0]              tile0;
    logic [19:0]             rom_pre;
    logic [19:0]             rom_masked;
    logic [19:0]             rom_next;
    logic                    line_end;

    function automatic logic [3:0] plane_colour(input logic [`TM_ROM_DW-1:0] w,
                                                input logic hf);
        if (hf)
            return {w[24], w[16], w[8], w[0]};
        return {w[31], w[23], w[15], w[7]};
    endfunction

    // screen flip mirrors the line inside its 256-line page
    assign vr_eff = vrender ^ {1'b0, {8{cfg.flip}}};

    // size dependent geometry and rom address format
    always_comb begin
        map_layer = 2'd3;
        buf0      = `TM_BUF0_32;
        tile0     = `TM_TILE_START_32;
        fine      = {4'd0, cfg.hpos[4:0]};
        last_word = 2'd3;
        rom_pre   = {code[13:0], vn[4:0] ^ {5{attr.vflip}}, attr.hflip};
        if (cfg.size[0]) begin
            map_layer = 2'd1;
            buf0      = `TM_BUF0_8;
            tile0     = `TM_TILE_START_8;
            fine      = {6'd0, cfg.hpos[2:0]};
            last_word = 2'd0;
            rom_pre   = {1'b0, code, vn[2:0] ^ {3{attr.vflip}}};
        end else if (cfg.size[1]) begin
            map_layer = 2'd2;
            buf0      = `TM_BUF0_16;
            tile0     = `TM_TILE_START_16;
            fine      = {5'd0, cfg.hpos[3:0]};
            last_word = 2'd1;
            rom_pre   = {code, vn[3:0] ^ {4{attr.vflip}}};
        end else if (!cfg.size[2]) begin
            map_layer = 2'd0; // no size selected, mapper flags it
        end
        rom_masked = {bank.mask, 16'hffff} & rom_pre;
        rom_next   = {bank.offset, 16'h0000} | rom_masked;
    end

    assign line_end = buf_wr && (buf_addr == `TM_BUF_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            done      <= 1'b0;
            tile_addr <= '0;
            rom_addr  <= '0;
            rom_half  <= 1'b0;
            rom_cs    <= 1'b0;
            buf_addr  <= '0;
            buf_wr    <= 1'b0;
            pix_cnt   <= '0;
            word_idx  <= '0;
        end else begin
            done   <= 1'b0;
            buf_wr <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        tile_addr <= tile0;
                        buf_addr  <= buf0 - fine - 9'd1; // pre-decremented, first write at buf0-fine
                        state     <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    tile_addr[0] <= 1'b1; // attribute follows the code
                    state        <= S_CODE;
                end
                S_CODE: state <= S_ATTR;
                S_ATTR: state <= S_MAP;
                S_MAP:  state <= S_ISSUE;
                S_ISSUE: begin
                    rom_addr  <= rom_next;
                    rom_half  <= attr.hflip;
                    rom_cs    <= 1'b1;
                    tile_addr <= tile_addr + 8'd1; // next code address
                    word_idx  <= 2'd0;
                    state     <= S_WAIT;
                end
                S_WAIT: begin
                    if (rom_ok) begin
                        pix_cnt <= 3'd0;
                        state   <= S_DRAW;
                        if (word_idx == last_word) begin
                            rom_cs <= 1'b0;
                        end else begin
                            // request the next word while this one is drawn
                            rom_half <= ~rom_half;
                            if (word_idx == 2'd1)
                                rom_addr[0] <= ~rom_addr[0]; // 32x32 second column pair
                        end
                    end
                end
                S_DRAW: begin
                    buf_wr   <= 1'b1;
                    buf_addr <= buf_addr + 9'd1;
                    pix_cnt  <= pix_cnt + 3'd1;
                    if (pix_cnt == 3'd7) begin
                        if (word_idx == last_word) begin
                            state <= S_ADDR; // next tile
                        end else begin
                            word_idx <= word_idx + 2'd1;
                            state    <= S_WAIT;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
            // line finished or aborted
            if (state != S_IDLE && (stop || line_end)) begin
                state  <= S_IDLE;
                done   <= 1'b1;
                buf_wr <= 1'b0;
                rom_cs <= 1'b0;
            end
        end
    end

    // tile payload and pixel shifter
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: vn <= cfg.vpos[4:0] + vr_eff[4:0];
            S_CODE: begin
                code     <= tile_data;
                map_code <= tile_data[15:6];
            end
            S_ATTR: attr <= tile_data;
            S_MAP:  bank <= sel;
            S_WAIT: begin
                if (rom_ok)
                    pxl <= rom_data;
            end
            S_DRAW: begin
                buf_data <= '{group:  attr.group,
                              pal:    attr.pal,
                              colour: bank.unmapped ? 4'hf : plane_colour(pxl, attr.hflip)};
                pxl      <= attr.hflip ? pxl >> 1 : pxl << 1;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/line_buffer.sv
// line_buffer: one-line memory, single write port and registered read port
`timescale 1ns/1ns
`include "tilemap_consts.svh"

module line_buffer #(
    parameter type entry_t = logic [10:0]
) (
    input  logic       clk,
    input  logic       wr,
    input  logic [8:0] wr_addr,
    input  entry_t     wr_data,
    input  logic [8:0] rd_addr,   // video side
    output entry_t     rd_data
);

    entry_t mem [`TM_BUF_DEPTH];

    // renderer side
    always_ff @(posedge clk) begin
        if (wr)
            mem[wr_addr] <= wr_data;
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- verilog/tilemap_top.sv
// tilemap_top: scroll layer line renderer with bank mapper and line buffer
`timescale 1ns/1ns
`include "tilemap_consts.svh"

module tilemap_top (
    input  logic                     clk,
    input  logic                     rst,
    input  tilemap_pkg::scroll_cfg_t cfg,
    input  logic [8:0]               vrender,
    input  logic                     start,
    input  logic                     stop,
    output logic                     done,
    input  logic [15:0]              bank_offset,
    input  logic [15:0]              bank_mask,
    output logic [7:0]               tile_addr,
    input  logic [15:0]              tile_data,
    output logic [19:0]              rom_addr,
    output logic                     rom_half,
    output logic                     rom_cs,
    input  logic [`TM_ROM_DW-1:0]    rom_data,
    input  logic                     rom_ok,
    input  logic [8:0]               rd_addr,
    output tilemap_pkg::pixel_t      rd_data
);

    logic [9:0]             map_code;
    logic [1:0]             map_layer;
    tilemap_pkg::bank_sel_t sel;
    logic [8:0]             buf_addr;
    tilemap_pkg::pixel_t    buf_data;
    logic                   buf_wr;

    tile_line_render u_render (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .vrender   (vrender),
        .start     (start),
        .stop      (stop),
        .done      (done),
        .tile_addr (tile_addr),
        .tile_data (tile_data),
        .map_code  (map_code),
        .map_layer (map_layer),
        .sel       (sel),
        .rom_addr  (rom_addr),
        .rom_half  (rom_half),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .rom_cs    (rom_cs),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data),
        .buf_wr    (buf_wr)
    );

    gfx_mapper u_mapper (
        .clk         (clk),
        .rst         (rst),
        .layer       (map_layer),
        .cin         (map_code),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .sel         (sel)
    );

    line_buffer #(
        .entry_t (tilemap_pkg::pixel_t)
    ) u_line_buffer (
        .clk     (clk),
        .wr      (buf_wr),
        .wr_addr (buf_addr),
        .wr_data (buf_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- verification/tilemap_sva.sv
// renderer control assertions: no idle writes, single cycle done, rom request held
`timescale 1ns/1ns

module tilemap_sva (
    input logic        clk,
    input logic        rst,
    input logic [2:0]  state,
    input logic        done,
    input logic        buf_wr,
    input logic        rom_cs,
    input logic        rom_ok,
    input logic [19:0] rom_addr
);

    localparam logic [2:0] IDLE = 3'd0;  // renderer idle state code

    no_write_in_idle: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE) |-> !buf_wr)
        else $error("line buffer written while the renderer is idle");

    done_single_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done held for more than one cycle");

    // rom request must not move before it is acknowledged
    rom_addr_held: assert property (@(posedge clk) disable iff (rst)
        (rom_cs && !rom_ok) |=> $stable(rom_addr))
        else $error("rom_addr changed while waiting for rom_ok");

endmodule

bind tile_line_render tilemap_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .done     (done),
    .buf_wr   (buf_wr),
    .rom_cs   (rom_cs),
    .rom_ok   (rom_ok),
    .rom_addr (rom_addr)
);

//--- verification/tilemap_tb.sv
// tilemap testbench with tile ram and rom models, reference line function, compare process and watchdog
`timescale 1ns/1ns
`include "tilemap_consts.svh"

module tilemap_tb;

    localparam int NUM_LINES  = 8;  // started lines over the whole run
    localparam int TIMEOUT_NS = NUM_LINES * 448 * 12 * 40;

    logic                     clk = 1'b0;
    logic                     rst = 1'b1;
    tilemap_pkg::scroll_cfg_t cfg;
    logic [8:0]               vrender;
    logic                     start;
    logic                     stop;
    logic                     done;
    logic [15:0]              bank_offset;
    logic [15:0]              bank_mask;
    logic [7:0]               tile_addr;
    logic [15:0]              tile_data = '0;
    logic [19:0]              rom_addr;
    logic                     rom_half;
    logic                     rom_cs;
    logic [`TM_ROM_DW-1:0]    rom_data = '0;
    logic                     rom_ok = 1'b0;
    logic [8:0]               rd_addr = '0;
    tilemap_pkg::pixel_t      rd_data;

    logic [15:0]         tile_ram [256];
    logic [7:0]          ram_addr_q = '0;
    logic [19:0]         req_addr = '0;  // rom request being served
    logic                req_half = 1'b0;
    logic                req_live = 1'b0;
    int                  lat_cnt = 0;
    tilemap_pkg::pixel_t got_line [`TM_BUF_DEPTH];
    tilemap_pkg::pixel_t prev_line [`TM_BUF_DEPTH];
    logic                sweep_req = 1'b0;
    logic                sweep_ack = 1'b0;
    int                  errors = 0;
    int                  checks = 0;

    always #20 clk = ~clk;

    tilemap_top u_tilemap_top (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .vrender     (vrender),
        .start       (start),
        .stop        (stop),
        .done        (done),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .tile_addr   (tile_addr),
        .tile_data   (tile_data),
        .rom_addr    (rom_addr),
        .rom_half    (rom_half),
        .rom_cs      (rom_cs),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    // rom content hash over every address bit and the half select
    function automatic logic [31:0] rom_word(input logic [19:0] addr, input logic half);
        logic [31:0] x;
        x = {11'd0, addr, half} * 32'h9e37_79b1;
        x = x ^ (x >> 15);
        x = x * 32'h85eb_ca6b;
        return x ^ (x >> 13);
    endfunction

    // tile ram with the word one cycle behind the address
    always @(negedge clk) begin
        tile_data  <= tile_ram[ram_addr_q];
        ram_addr_q <= tile_addr;
    end

    // graphics rom with random latency and rom_ok held until the request changes
    always @(negedge clk) begin
        if (rst || !rom_cs) begin
            rom_ok   <= 1'b0;
            req_live <= 1'b0;
        end else if (!req_live || (rom_ok && ({rom_addr, rom_half} != {req_addr, req_half}))) begin
            req_addr <= rom_addr;
            req_half <= rom_half;
            lat_cnt  <= $urandom_range(6, 1);
            rom_ok   <= 1'b0;
            req_live <= 1'b1;
        end else if (!rom_ok) begin
            if (lat_cnt <= 1) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(req_addr, req_half);
            end else begin
                lat_cnt <= lat_cnt - 1;
            end
        end
    end

    // expected buffer entry from the tile row, mapper, address and pixel rules
    function automatic tilemap_pkg::pixel_t expected_pixel(input int a);
        int                      w;
        int                      buf0;
        int                      tile0;
        int                      p;
        int                      n;
        int                      c;
        int                      wi;
        logic [15:0]             code;
        tilemap_pkg::tile_attr_t attr;
        logic [8:0]              vr;
        logic [4:0]              vn;
        logic [4:0]              row;
        logic [19:0]             ra;
        logic [31:0]             word;
        logic [3:0]              msk;
        logic [3:0]              off;
        tilemap_pkg::pixel_t     px;
        if (cfg.size[0]) begin
            w     = 8;
            buf0  = int'(`TM_BUF0_8);
            tile0 = int'(`TM_TILE_START_8);
        end else if (cfg.size[1]) begin
            w     = 16;
            buf0  = int'(`TM_BUF0_16);
            tile0 = int'(`TM_TILE_START_16);
        end else begin
            w     = 32;
            buf0  = int'(`TM_BUF0_32);
            tile0 = int'(`TM_TILE_START_32);
        end
        p    = a - (buf0 - int'(cfg.hpos) % w);
        n    = p / w;   // tile in the row
        c    = p % w;   // column in the tile
        wi   = c / 8;   // rom word in the tile row
        code = tile_ram[8'(tile0 + 2 * n)];
        attr = tile_ram[8'(tile0 + 2 * n + 1)];
        vr   = vrender ^ {1'b0, {8{cfg.flip}}};
        vn   = cfg.vpos[4:0] + vr[4:0];
        row  = 5'(int'(vn) % w);
        if (attr.vflip)
            row = row ^ 5'(w - 1);
        case (w)
            8:       ra = {1'b0, code, row[2:0]};
            16:      ra = {code, row[3:0]};
            default: ra = {code[13:0], row, attr.hflip ^ (wi >= 2)}; // column pair select
        endcase
        msk = bank_mask[{code[15:14], 2'b00} +: 4];
        off = bank_offset[{code[15:14], 2'b00} +: 4];
        ra[19:16] = (ra[19:16] & msk) | off;
        word = rom_word(ra, attr.hflip ^ wi[0]);
        word = attr.hflip ? word >> (c % 8) : word << (c % 8);
        px.group  = attr.group;
        px.pal    = attr.pal;
        px.colour = attr.hflip ? {word[24], word[16], word[8], word[0]}
                               : {word[31], word[23], word[15], word[7]};
        if (msk == 4'h0)
            px.colour = 4'hf;  // unmapped tile
        return px;
    endfunction

    task automatic check_value(input string what, input int addr, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t addr %0d %s: got %0h expected %0h",
                     $time, addr, what, got, exp);
        end
    endtask

    // video side sweep over the visible part of the buffer
    always begin : compare_proc
        wait (sweep_req);
        for (int a = 64; a <= int'(`TM_BUF_LAST); a++) begin
            @(negedge clk);
            rd_addr = 9'(a);
            @(negedge clk);
            got_line[9'(a)] = rd_data;
            check_value("pixel", a, {21'd0, rd_data}, {21'd0, expected_pixel(a)});
        end
        sweep_ack = 1'b1;
        wait (!sweep_req);
        sweep_ack = 1'b0;
    end

    task automatic fill_tile_ram(input logic flips);
        logic [15:0] w;
        for (int i = 0; i < 256; i++) begin
            w = 16'($urandom);
            if (i[0] && !flips)
                w[6:5] = 2'b00; // attribute without tile flips
            tile_ram[8'(i)] = w;
        end
    endtask

    task automatic set_cfg(input logic [2:0] size, input logic [15:0] hpos,
                           input logic [15:0] vpos, input logic flip, input logic [8:0] vr);
        @(negedge clk);
        cfg.size  = size;
        cfg.hpos  = hpos;
        cfg.vpos  = vpos;
        cfg.flip  = flip;
        vrender   = vr;
    endtask

    task automatic render_line;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done)
            @(negedge clk);
    endtask

    task automatic compare_line;
        sweep_req = 1'b1;
        wait (sweep_ack);
        sweep_req = 1'b0;
        wait (!sweep_ack);
    endtask

    task automatic compare_with_prev;
        for (int a = 64; a <= int'(`TM_BUF_LAST); a++)
            check_value("repeat", a, {21'd0, got_line[9'(a)]}, {21'd0, prev_line[9'(a)]});
    endtask

    task automatic stop_mid_line;
        logic seen;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat ($urandom_range(400, 100)) @(negedge clk);
        stop = 1'b1;
        @(negedge clk);
        stop = 1'b0;
        seen = done;
        if (!seen) begin
            @(negedge clk);
            seen = done;
        end
        check_value("done after stop", 0, {31'd0, seen}, 32'd1);
    endtask

    initial begin : main_proc
        void'($urandom(32'h65dc_4ebf));
        rst         = 1'b1;
        cfg         = '0;
        cfg.size    = 3'b001;
        vrender     = '0;
        start       = 1'b0;
        stop        = 1'b0;
        bank_offset = 16'h0000;
        bank_mask   = 16'hffff;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // 8x8, no scroll, every bank mapped
        fill_tile_ram(1'b0);
        set_cfg(3'b001, 16'h0000, 16'h0000, 1'b0, 9'd37);
        render_line;
        compare_line;

        // 16x16 with tile flips and vertical scroll
        fill_tile_ram(1'b1);
        set_cfg(3'b010, 16'h0000, 16'h0025, 1'b0, 9'd90);
        render_line;
        compare_line;

        // 32x32 with fine scroll and screen flip
        fill_tile_ram(1'b1);
        set_cfg(3'b100, 16'h0113, 16'h0007, 1'b1, 9'd200);
        render_line;
        compare_line;

        // bank 0 empty, the other banks relocated
        fill_tile_ram(1'b1);
        tile_ram[8'(`TM_TILE_START_16 + 4)][15:14] = 2'b00; // first fully visible tile in bank 0
        for (int b = 1; b < 4; b++) // following tiles in the relocated banks
            tile_ram[8'(`TM_TILE_START_16 + 4 + 2 * b)][15:14] = 2'(b);
        bank_mask   = 16'h3f70;
        bank_offset = 16'h48c0;
        set_cfg(3'b010, 16'h0009, 16'h0013, 1'b0, 9'd121);
        render_line;
        compare_line;

        // same line twice, then an aborted line of another size, then again
        render_line;
        compare_line;
        prev_line = got_line;
        render_line;
        compare_line;
        compare_with_prev;
        set_cfg(3'b100, 16'h0004, 16'h0031, 1'b1, 9'd17);
        stop_mid_line;
        repeat (4) @(negedge clk);
        set_cfg(3'b010, 16'h0009, 16'h0013, 1'b0, 9'd121);
        render_line;
        compare_line;
        compare_with_prev;

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: the renderer did not finish all lines within %0d ns", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- sim.f
+incdir+verilog
verilog/tilemap_pkg.sv
verilog/gfx_mapper.sv
verilog/tile_line_render.sv
verilog/line_buffer.sv
verilog/tilemap_top.sv
verification/tilemap_sva.sv
verification/tilemap_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the tilemap testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f sim.f --top-module tilemap_tb \
    -Mdir "$BUILD" -o tilemap_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/tilemap_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

echo "simulation finished without failure"
exit 0
